//--- dv/dcache_mem_model.sv
// behavioral line memory with random response latency for the data cache
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_mem_model (
    input  logic              clk,
    input  logic              rd_req,
    input  dcache_pkg::addr_t rd_addr,
    output logic              rd_valid,
    output dcache_pkg::line_t rd_line,
    input  logic              wr_req,
    input  dcache_pkg::addr_t wr_addr,
    input  dcache_pkg::line_t wr_line,
    output logic              wr_done
);
    import dcache_pkg::*;

    // only written-back words are held, the rest follow the fill pattern
    word_t mem [addr_t];

    function automatic word_t read_word(input addr_t a);
        addr_t key;
        key = {a[`DC_ADDR_W-1:2], 2'b00};
        if (mem.exists(key)) begin
            return mem[key];
        end
        return key ^ 32'hA5A5A5A5;
    endfunction

    initial begin
        addr_t base;
        int    wait_cycles;
        logic  is_read;
        rd_valid = 1'b0;
        wr_done  = 1'b0;
        rd_line  = '0;
        forever begin
            @(posedge clk);
            if (rd_req || wr_req) begin
                is_read = rd_req;
                base    = is_read ? rd_addr : wr_addr;
                base[`DC_OFFSET_W-1:0] = '0;
                // write-back data is taken with the request strobe
                if (!is_read) begin
                    for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                        mem[base + 4*w] = wr_line[w*`DC_WORD_W +: `DC_WORD_W];
                    end
                end
                wait_cycles = 2 + ($urandom % 5);
                repeat (wait_cycles - 1) @(posedge clk);
                #2;
                if (is_read) begin
                    for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                        rd_line[w*`DC_WORD_W +: `DC_WORD_W] = read_word(base + 4*w);
                    end
                    rd_valid = 1'b1;
                end else begin
                    wr_done = 1'b1;
                end
                @(posedge clk);
                #2;
                rd_valid = 1'b0;
                wr_done  = 1'b0;
            end
        end
    end

endmodule

//--- dv/dcache_tb.sv
// data cache testbench with shadow memory, checking assertions and watchdog
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam addr_t line_a = 32'h0000_1030;
    localparam addr_t line_b = 32'h0000_2030;
    localparam addr_t line_c = 32'h0000_3030;

    logic  clk;
    logic  rst_n;
    logic  req;
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_strb;
    logic  busy;
    logic  resp_valid;
    word_t resp_rdata;
    logic  mem_rd_req;
    addr_t mem_rd_addr;
    logic  mem_rd_valid;
    line_t mem_rd_line;
    logic  mem_wr_req;
    addr_t mem_wr_addr;
    line_t mem_wr_line;
    logic  mem_wr_done;

    // expectations driven along with each request
    logic  drv_hit;
    logic  drv_wb;
    addr_t drv_wb_addr;
    line_t drv_wb_line;
    word_t drv_word;

    // the request the cache is working on
    logic  pend_live;
    logic  pend_load;
    logic  pend_hit;
    logic  pend_wb;
    logic  pend_wb_seen;
    logic  pend_rd_seen;
    addr_t pend_addr;
    addr_t pend_line_addr;
    addr_t pend_wb_addr;
    word_t pend_word;
    line_t pend_wb_line;

    word_t shadow [addr_t];
    int    errors = 0;
    int    n_issued = 0;
    int    cycles = 0;

    dcache_top u_dcache_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_strb     (req_strb),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_line  (mem_rd_line),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_line  (mem_wr_line),
        .mem_wr_done  (mem_wr_done)
    );

    dcache_mem_model u_mem_model (
        .clk      (clk),
        .rd_req   (mem_rd_req),
        .rd_addr  (mem_rd_addr),
        .rd_valid (mem_rd_valid),
        .rd_line  (mem_rd_line),
        .wr_req   (mem_wr_req),
        .wr_addr  (mem_wr_addr),
        .wr_line  (mem_wr_line),
        .wr_done  (mem_wr_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic addr_t word_key(input addr_t a);
        return {a[`DC_ADDR_W-1:2], 2'b00};
    endfunction

    function automatic word_t shadow_read(input addr_t a);
        if (shadow.exists(word_key(a))) begin
            return shadow[word_key(a)];
        end
        return word_key(a) ^ 32'hA5A5A5A5;
    endfunction

    function automatic line_t shadow_line(input addr_t a);
        line_t line;
        addr_t base;
        base = {a[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            line[w*`DC_WORD_W +: `DC_WORD_W] = shadow_read(base + 4*w);
        end
        return line;
    endfunction

    function automatic void shadow_write(input addr_t a, input word_t d, input strb_t s);
        word_t cur;
        cur = shadow_read(a);
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (s[b]) begin
                cur[8*b +: 8] = d[8*b +: 8];
            end
        end
        shadow[word_key(a)] = cur;
    endfunction

    task automatic value_mismatch(input string name, input line_t got, input line_t exp);
        errors++;
        $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic protocol_fault(input string what);
        errors++;
        $display("check failed at %0t: %s", $time, what);
    endtask

    // waits for busy low, then holds req for one edge
    task automatic issue(input logic wr, input addr_t a, input word_t d, input strb_t s,
                         input logic exp_hit, input logic exp_wb, input addr_t wb_a);
        while (busy) begin
            @(posedge clk);
            #2;
        end
        req         = 1'b1;
        req_write   = wr;
        req_addr    = a;
        req_wdata   = d;
        req_strb    = s;
        drv_hit     = exp_hit;
        drv_wb      = exp_wb;
        drv_wb_addr = wb_a;
        drv_wb_line = shadow_line(wb_a);
        drv_word    = shadow_read(a);
        if (wr) begin
            shadow_write(a, d, s);
        end
        n_issued++;
        @(posedge clk);
        #2;
        req     = 1'b0;
        drv_hit = 1'b0;
        drv_wb  = 1'b0;
    endtask

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_live    <= 1'b0;
            pend_load    <= 1'b0;
            pend_hit     <= 1'b0;
            pend_wb      <= 1'b0;
            pend_wb_seen <= 1'b0;
            pend_rd_seen <= 1'b0;
            pend_addr    <= '0;
            pend_wb_addr <= '0;
            pend_word    <= '0;
            pend_wb_line <= '0;
        end else if (req) begin
            pend_live    <= 1'b1;
            pend_load    <= !req_write;
            pend_hit     <= drv_hit;
            pend_wb      <= drv_wb;
            pend_wb_seen <= 1'b0;
            pend_rd_seen <= 1'b0;
            pend_addr    <= req_addr;
            pend_wb_addr <= drv_wb_addr;
            pend_word    <= drv_word;
            pend_wb_line <= drv_wb_line;
        end else begin
            if (resp_valid) begin
                pend_live <= 1'b0;
            end
            if (mem_wr_req) begin
                pend_wb_seen <= 1'b1;
            end
            if (mem_rd_req) begin
                pend_rd_seen <= 1'b1;
            end
        end
    end

    assign pend_line_addr = {pend_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> !busy && !resp_valid && !mem_rd_req && !mem_wr_req)
        else protocol_fault("cache outputs active during or right after reset");

    a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> pend_live)
        else protocol_fault("response without an outstanding request");

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && pend_load |-> resp_rdata == pend_word)
        else value_mismatch("resp_rdata", $sampled(resp_rdata), $sampled(pend_word));

    a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        req && drv_hit |=> resp_valid && !mem_rd_req && !mem_wr_req)
        else protocol_fault("expected hit did not respond in the next cycle");

    a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_req |-> mem_rd_addr == pend_line_addr)
        else value_mismatch("mem_rd_addr", $sampled(mem_rd_addr), $sampled(pend_line_addr));

    a_miss_fetches: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && pend_live && !pend_hit |-> pend_rd_seen)
        else protocol_fault("miss answered without a line read");

    a_wb_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_req |-> pend_wb)
        else protocol_fault("write-back of a line that should be clean");

    a_wb_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_req && pend_wb |-> mem_wr_addr == pend_wb_addr)
        else value_mismatch("mem_wr_addr", $sampled(mem_wr_addr), $sampled(pend_wb_addr));

    a_wb_line: assert property (@(posedge clk) disable iff (!rst_n)
        mem_wr_req && pend_wb |-> mem_wr_line == pend_wb_line)
        else value_mismatch("mem_wr_line", $sampled(mem_wr_line), $sampled(pend_wb_line));

    a_wb_before_rd: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rd_req && pend_wb |-> pend_wb_seen)
        else protocol_fault("line read issued before the dirty write-back");

    a_wb_done: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && pend_wb |-> pend_wb_seen)
        else protocol_fault("dirty victim replaced without a write-back");

    // limit grows with each issued request
    initial begin
        while (cycles <= 200 * (n_issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: cache stopped making progress after %0d cycles", cycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(68));
        rst_n       = 1'b0;
        req         = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_strb    = '0;
        drv_hit     = 1'b0;
        drv_wb      = 1'b0;
        drv_wb_addr = '0;
        drv_wb_line = '0;
        drv_word    = '0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // clean miss, then back-to-back hits on the refilled line
        issue(1'b0, 32'h1000_0040, '0, '0, 1'b0, 1'b0, '0);
        issue(1'b0, 32'h1000_0044, '0, '0, 1'b1, 1'b0, '0);
        issue(1'b0, 32'h1000_004C, '0, '0, 1'b1, 1'b0, '0);
        issue(1'b0, 32'h1000_0040, '0, '0, 1'b1, 1'b0, '0);
        // partial store and a load of the same word
        issue(1'b1, 32'h1000_0048, $urandom, 4'b0101, 1'b1, 1'b0, '0);
        issue(1'b0, 32'h1000_0048, '0, '0, 1'b1, 1'b0, '0);

        // set 3 with b left clean, so c evicts it silently
        issue(1'b1, line_a, $urandom, 4'b1111, 1'b0, 1'b0, '0);
        issue(1'b0, line_b, '0, '0, 1'b0, 1'b0, '0);
        issue(1'b0, line_a, '0, '0, 1'b1, 1'b0, '0);
        issue(1'b0, line_c, '0, '0, 1'b0, 1'b0, '0);

        // again with b dirty, c must push b out first
        issue(1'b1, line_a + 4, $urandom, 4'b0011, 1'b1, 1'b0, '0);
        issue(1'b1, line_b + 8, $urandom, 4'b1110, 1'b0, 1'b0, '0);
        issue(1'b0, line_a, '0, '0, 1'b1, 1'b0, '0);
        issue(1'b0, line_c, '0, '0, 1'b0, 1'b1, line_b);
        // b comes back from memory, a is the dirty victim now
        issue(1'b0, line_b + 8, '0, '0, 1'b0, 1'b1, line_a);
        issue(1'b0, line_c + 4, '0, '0, 1'b1, 1'b0, '0);
        issue(1'b0, line_a + 4, '0, '0, 1'b0, 1'b0, '0);
        issue(1'b0, line_a, '0, '0, 1'b1, 1'b0, '0);

        while (pend_live) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("run complete: %0d requests, %0d errors", n_issued, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- include/dcache_params.svh
// geometry macros for the two-way data cache
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// cpu address and data widths
`define DC_ADDR_W      32
`define DC_WORD_W      32

// line and array geometry
`define DC_LINE_WORDS  4
`define DC_SETS        16
`define DC_WAYS        2

// address split, tag | index | offset
`define DC_OFFSET_W    4
`define DC_INDEX_W     4
`define DC_TAG_W       24

// word select sits in the upper offset bits
`define DC_WSEL_W      2
`define DC_STRB_W      4

`endif

//--- list.f
+incdir+include
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_miss_ctrl.sv
logic/dcache_top.sv
dv/dcache_mem_model.sv
dv/dcache_tb.sv

//--- logic/dcache_data_store.sv
// line storage for both ways with byte-merged stores and line refill
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_data_store (
    input  logic               clk,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::wsel_t  wsel,
    input  dcache_pkg::way_t   way,
    input  logic               store_en,
    input  dcache_pkg::word_t  store_data,
    input  dcache_pkg::strb_t  store_strb,
    input  logic               refill_en,
    input  dcache_pkg::line_t  refill_line,
    output dcache_pkg::word_t  load_word,
    output dcache_pkg::line_t  victim_line
);
    import dcache_pkg::*;

    line_t lines_q [`DC_WAYS][`DC_SETS];
    word_t merged_word;
    line_t store_line;

    // combinational read of the addressed line
    assign victim_line = lines_q[way][index];
    assign load_word   = victim_line[wsel*`DC_WORD_W +: `DC_WORD_W];

    // replace only the strobed byte lanes
    always_comb begin
        for (int b = 0; b < `DC_STRB_W; b++) begin
            merged_word[8*b +: 8] = store_strb[b] ? store_data[8*b +: 8]
                                                  : load_word[8*b +: 8];
        end
        store_line = victim_line;
        store_line[wsel*`DC_WORD_W +: `DC_WORD_W] = merged_word;
    end

    always_ff @(posedge clk) begin
        if (refill_en) begin
            lines_q[way][index] <= refill_line;
        end else if (store_en) begin
            lines_q[way][index] <= store_line;
        end
    end

    // stores only happen on a hit, refills only while missing
    a_no_store_during_refill: assert property (
        @(posedge clk) !(store_en && refill_en)
    );

endmodule

//--- logic/dcache_miss_ctrl.sv
// request register and the lookup, write-back and refill state machine
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_miss_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  logic                req_write,
    input  dcache_pkg::addr_t   req_addr,
    input  dcache_pkg::word_t   req_wdata,
    input  dcache_pkg::strb_t   req_strb,
    input  logic                hit,
    input  dcache_pkg::way_t    hit_way,
    input  dcache_pkg::way_t    victim_way,
    input  logic                victim_dirty,
    input  dcache_pkg::tag_t    victim_tag,
    input  dcache_pkg::word_t   load_word,
    input  logic                mem_rd_valid,
    input  logic                mem_wr_done,
    output logic                busy,
    output logic                resp_valid,
    output dcache_pkg::word_t   resp_rdata,
    output dcache_pkg::index_t  look_index,
    output dcache_pkg::tag_t    look_tag,
    output dcache_pkg::wsel_t   look_wsel,
    output logic                touch,
    output dcache_pkg::way_t    sel_way,
    output logic                store_en,
    output dcache_pkg::word_t   store_data,
    output dcache_pkg::strb_t   store_strb,
    output logic                refill_en,
    output logic                mem_rd_req,
    output dcache_pkg::addr_t   mem_rd_addr,
    output logic                mem_wr_req,
    output dcache_pkg::addr_t   mem_wr_addr
);
    import dcache_pkg::*;

    miss_state_t state_q;
    miss_state_t state_d;
    logic        req_valid_q;
    logic        write_q;
    tag_t        tag_q;
    index_t      index_q;
    wsel_t       wsel_q;
    word_t       wdata_q;
    strb_t       strb_q;
    // read request owed after a write-back completes
    logic        rd_pend_q;
    logic        lookup_miss;
    logic        serve;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req;
        end
    end

    // payload is held for the whole miss
    always_ff @(posedge clk) begin
        if (req) begin
            write_q <= req_write;
            tag_q   <= req_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
            index_q <= req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
            wsel_q  <= req_addr[`DC_OFFSET_W-`DC_WSEL_W +: `DC_WSEL_W];
            wdata_q <= req_wdata;
            strb_q  <= req_strb;
        end
    end

    assign lookup_miss = (state_q == LOOKUP) && req_valid_q && !hit;
    // refill_done re-runs the lookup on the held request
    assign serve = hit && (((state_q == LOOKUP) && req_valid_q) || (state_q == REFILL_DONE));

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (lookup_miss) begin
                    state_d = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (mem_wr_done) begin
                    state_d = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rd_valid) begin
                    state_d = REFILL_DONE;
                end
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= LOOKUP;
            rd_pend_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rd_pend_q <= (state_q == MISS_DIRTY) && mem_wr_done;
        end
    end

    // cpu side
    assign busy       = lookup_miss || (state_q == MISS_DIRTY) || (state_q == MISS_CLEAN);
    assign resp_valid = serve;
    assign resp_rdata = load_word;

    // array side
    assign look_index = index_q;
    assign look_tag   = tag_q;
    assign look_wsel  = wsel_q;
    assign sel_way    = hit ? hit_way : victim_way;
    assign touch      = serve;
    assign store_en   = serve && write_q;
    assign store_data = wdata_q;
    assign store_strb = strb_q;
    assign refill_en  = (state_q == MISS_CLEAN) && mem_rd_valid;

    // line-aligned memory requests
    assign mem_wr_req  = lookup_miss && victim_dirty;
    assign mem_wr_addr = {victim_tag, index_q, {`DC_OFFSET_W{1'b0}}};
    assign mem_rd_req  = (lookup_miss && !victim_dirty) || rd_pend_q;
    assign mem_rd_addr = {tag_q, index_q, {`DC_OFFSET_W{1'b0}}};

    a_req_only_when_free: assert property (
        @(posedge clk) disable iff (!rst_n) req |-> !busy
    );

    a_rd_req_enters_refill: assert property (
        @(posedge clk) disable iff (!rst_n) mem_rd_req |=> (state_q == MISS_CLEAN)
    );

    // the write-back owns the memory port until it completes
    a_quiet_during_writeback: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == MISS_DIRTY) |-> !mem_rd_req && !mem_wr_req
    );

endmodule

//--- logic/dcache_pkg.sv
// shared vector types and the miss state enum for the data cache
`include "dcache_params.svh"

package dcache_pkg;

    // address and data
    typedef logic [`DC_ADDR_W-1:0] addr_t;
    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_STRB_W-1:0] strb_t;

    // address fields
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [`DC_WSEL_W-1:0]  wsel_t;

    // whole line, word 0 in the low bits
    typedef logic [`DC_LINE_WORDS*`DC_WORD_W-1:0] line_t;

    typedef logic [0:0] way_t;

    // lookup and miss handling
    typedef enum logic [1:0] {
        LOOKUP,
        MISS_DIRTY,
        MISS_CLEAN,
        REFILL_DONE
    } miss_state_t;

endpackage

//--- logic/dcache_tag_store.sv
// tag, valid, dirty and lru arrays with hit detection and victim choice
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tag_store (
    input  logic              clk,
    input  logic              rst_n,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  logic              touch,
    input  dcache_pkg::way_t   touch_way,
    input  logic              mark_dirty,
    input  logic              refill,
    input  dcache_pkg::way_t   refill_way,
    output logic              hit,
    output dcache_pkg::way_t   hit_way,
    output dcache_pkg::way_t   victim_way,
    output logic              victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tag_t               tags_q  [`DC_WAYS][`DC_SETS];
    logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
    logic [`DC_SETS-1:0] dirty_q [`DC_WAYS];
    // one bit per set, names the way to replace next
    logic [`DC_SETS-1:0] lru_q;
    logic [`DC_WAYS-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = valid_q[w][index] && (tags_q[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // an empty way is filled before anything is evicted
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    assign victim_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];
    assign victim_tag   = tags_q[victim_way][index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            // new line arrives clean
            if (refill) begin
                valid_q[refill_way][index] <= 1'b1;
                dirty_q[refill_way][index] <= 1'b0;
            end
            if (mark_dirty) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
            if (touch) begin
                lru_q[index] <= ~touch_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tags_q[refill_way][index] <= tag;
        end
    end

    // refill always picks the victim, so a tag never lands in both ways
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n) !(way_hit[0] && way_hit[1])
    );

endmodule

//--- logic/dcache_top.sv
// data cache top level joining the miss controller and both arrays
`timescale 1ns/1ns

module dcache_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  logic              req_write,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_strb,
    output logic              busy,
    output logic              resp_valid,
    output dcache_pkg::word_t resp_rdata,
    output logic              mem_rd_req,
    output dcache_pkg::addr_t mem_rd_addr,
    input  logic              mem_rd_valid,
    input  dcache_pkg::line_t mem_rd_line,
    output logic              mem_wr_req,
    output dcache_pkg::addr_t mem_wr_addr,
    output dcache_pkg::line_t mem_wr_line,
    input  logic              mem_wr_done
);
    import dcache_pkg::*;

    index_t look_index;
    tag_t   look_tag;
    wsel_t  look_wsel;
    logic   touch;
    way_t   sel_way;
    logic   store_en;
    word_t  store_data;
    strb_t  store_strb;
    logic   refill_en;
    logic   hit;
    way_t   hit_way;
    way_t   victim_way;
    logic   victim_dirty;
    tag_t   victim_tag;
    word_t  load_word;

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_strb     (req_strb),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .load_word    (load_word),
        .mem_rd_valid (mem_rd_valid),
        .mem_wr_done  (mem_wr_done),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .resp_rdata   (resp_rdata),
        .look_index   (look_index),
        .look_tag     (look_tag),
        .look_wsel    (look_wsel),
        .touch        (touch),
        .sel_way      (sel_way),
        .store_en     (store_en),
        .store_data   (store_data),
        .store_strb   (store_strb),
        .refill_en    (refill_en),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_addr  (mem_wr_addr)
    );

    // a store hit is what makes a line dirty
    dcache_tag_store u_tag_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .index        (look_index),
        .tag          (look_tag),
        .touch        (touch),
        .touch_way    (sel_way),
        .mark_dirty   (store_en),
        .refill       (refill_en),
        .refill_way   (sel_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    // victim line goes straight out as write-back data
    dcache_data_store u_data_store (
        .clk         (clk),
        .index       (look_index),
        .wsel        (look_wsel),
        .way         (sel_way),
        .store_en    (store_en),
        .store_data  (store_data),
        .store_strb  (store_strb),
        .refill_en   (refill_en),
        .refill_line (mem_rd_line),
        .load_word   (load_word),
        .victim_line (mem_wr_line)
    );

endmodule
